/* sources.f */
+incdir+verification
hw/opl_pkg.sv
hw/op_slot_sequencer.sv
hw/op_connection_router.sv
hw/op_phase_generator.sv
hw/op_waveform_unit.sv
hw/op_output_bank.sv
hw/opl_operator_core.sv
verification/tb_opl_operator_core.sv

/* Makefile */
# Verilator build and run of the operator core testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_opl_operator_core
FILELIST = sources.f
OBJDIR   = obj_dir

.PHONY: sim clean

# the run passes only if the testbench prints the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

/* verification/opl_ref_model.svh */
// ================================================
// Software model of the operator core. Included in
// the testbench module; model_round() advances all
// 18 slots once per accepted sample strobe.
// ================================================
`ifndef OPL_REF_MODEL_SVH
`define OPL_REF_MODEL_SVH

logic [PHASE_WIDTH-1:0] model_phase [NUM_SLOTS];
op_out_t                model_out [NUM_SLOTS];  // expected outputs after the round

function automatic void model_reset();
    for (int s = 0; s < NUM_SLOTS; s++) begin
        model_phase[s] = '0;
        model_out[s]   = '0;
    end
endfunction

// the carrier of a channel sits 3 slots above this modulator slot
function automatic int modulator_slot(int c);
    return (c < 3) ? c : (c < 6) ? c + 3 : c + 6;
endfunction

function automatic int slot_channel(int s);
    int found;
    found = 0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (s == modulator_slot(c) || s == modulator_slot(c) + 3)
            found = c;
    end
    return found;
endfunction

function automatic int triangle_sample(int unsigned ph, int mod, int tl_val);
    int idx;
    int q;
    int mag;
    idx = (int'(ph >> (PHASE_WIDTH - WAVE_INDEX_WIDTH)) + (mod & 1023)) % 1024;
    q   = idx % 512;
    mag = (q < 256) ? q : 511 - q;
    mag = (mag * 16) >> (tl_val >> 3);  // top 3 bits of tl
    return (idx < 512) ? mag : -mag;
endfunction

function automatic void model_round();
    int  ch;
    int  k;
    int  mod;
    int  inc;
    bit  chained;
    bit  fb_on;
    for (int s = 0; s < NUM_SLOTS; s++) begin
        ch      = slot_channel(s);
        k       = 0;
        mod     = 0;
        fb_on   = 1'b0;
        chained = 1'b0;
        if (s >= 6 && s < 12) begin  // third and fourth operator of a chain
            k       = (s - 6) % 3;
            chained = connection_sel[k];
        end
        if (chained) begin
            ch = k;
            if (s < 9)
                mod = (!cnt[k] && cnt[k + 3]) ? 0 : int'(model_out[k + 3]);
            else
                mod = (cnt[k] && cnt[k + 3]) ? 0 : int'(model_out[k + 6]);
        end else if (s == modulator_slot(ch) + 3) begin
            if (!cnt[ch])
                mod = int'(model_out[s - 3]);  // modulator of this round
        end else begin
            fb_on = 1'b1;
        end
        if (fb_on && fb[ch] != 0)
            mod = int'(model_out[s]) >>> (8 - int'(fb[ch]));  // previous round
        if (kon[ch]) begin
            inc = ((int'(fnum[ch]) << block[ch]) * int'(mult[s])) & ((1 << PHASE_WIDTH) - 1);
            model_phase[s] = PHASE_WIDTH'(int'(model_phase[s]) + inc);
            model_out[s]   = op_out_t'(triangle_sample(model_phase[s], mod, int'(tl[s])));
        end else begin
            model_phase[s] = '0;
            model_out[s]   = '0;
        end
    end
endfunction

`endif

/* verification/tb_opl_operator_core.sv */
// ================================================
// Testbench for the FM operator core. Drives random
// register sets through 2-op, 4-op, feedback and
// key-off cases and checks every round vs a model.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tb_opl_operator_core
    import opl_pkg::*;
();

    localparam int ROUND_CYCLES   = NUM_SLOTS * OP_SLOT_CYCLES + 1;
    localparam int TEST_ROUNDS    = 30;  // 28 strobed rounds plus 2 idle watch windows
    localparam int TIMEOUT_CYCLES = TEST_ROUNDS * ROUND_CYCLES + 200;

    logic                         clk;
    logic                         rst;
    logic                         sample_clk_en;
    logic [FNUM_WIDTH-1:0]        fnum [NUM_CHANNELS];
    logic [BLOCK_WIDTH-1:0]       block [NUM_CHANNELS];
    logic                         kon [NUM_CHANNELS];
    logic [FB_WIDTH-1:0]          fb [NUM_CHANNELS];
    logic                         cnt [NUM_CHANNELS];
    logic [MULT_WIDTH-1:0]        mult [NUM_SLOTS];
    logic [TL_WIDTH-1:0]          tl [NUM_SLOTS];
    logic [NUM_FOUR_OP_PAIRS-1:0] connection_sel;
    op_out_t                      operator_out [NUM_SLOTS];
    logic                         sample_done;

    int seed;
    int cycle_count = 0;
    int strobe_cycle = 0;
    int done_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    bit round_pending = 1'b0;

    `include "opl_ref_model.svh"

    opl_operator_core uut (
        .clk, .rst, .sample_clk_en, .fnum, .block, .kon, .fb, .cnt,
        .mult, .tl, .connection_sel, .operator_out, .sample_done
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // compare at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (sample_done) begin
            if (!round_pending) begin
                other_errors++;
                $display("Error at %0t: sample_done without an accepted strobe", $time);
            end else begin
                if (cycle_count - strobe_cycle != ROUND_CYCLES) begin
                    other_errors++;
                    $display("Error at %0t: sample_done came %0d cycles after the strobe",
                             $time, cycle_count - strobe_cycle);
                end
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    if (operator_out[s] !== model_out[s]) begin
                        value_errors++;
                        $display("Fail at %0t: operator_out[%0d] = %0d, expected %0d",
                                 $time, s, operator_out[s], model_out[s]);
                    end
                end
            end
            round_pending = 1'b0;
            done_count++;
        end
    end

    task automatic randomize_regs();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum[c]  = FNUM_WIDTH'($random(seed));
            block[c] = BLOCK_WIDTH'($random(seed));
            kon[c]   = 1'b1;
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            mult[s] = MULT_WIDTH'($random(seed));
            tl[s]   = TL_WIDTH'($random(seed));
        end
    endtask

    // one strobe and an optional second one inside the busy round
    task automatic run_round(int extra_strobe_delay);
        int prev_done;
        prev_done = done_count;
        @(negedge clk);
        sample_clk_en = 1'b1;
        strobe_cycle  = cycle_count;
        round_pending = 1'b1;
        model_round();
        @(negedge clk);
        sample_clk_en = 1'b0;
        if (extra_strobe_delay > 0) begin
            repeat (extra_strobe_delay) @(negedge clk);
            sample_clk_en = 1'b1;  // must be ignored
            @(negedge clk);
            sample_clk_en = 1'b0;
        end
        wait (done_count != prev_done);
    endtask

    initial begin
        seed           = 12;
        rst            = 1'b1;
        sample_clk_en  = 1'b0;
        connection_sel = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum[c]  = '0;
            block[c] = '0;
            kon[c]   = 1'b0;
            fb[c]    = '0;
            cnt[c]   = 1'b0;
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            mult[s] = '0;
            tl[s]   = '0;
        end
        model_reset();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (operator_out[s] !== '0) begin
                value_errors++;
                $display("Fail at %0t: operator_out[%0d] = %0d, expected 0",
                         $time, s, operator_out[s]);
            end
        end
        repeat (ROUND_CYCLES + 3) @(negedge clk);  // no done without a strobe

        // strobe while busy is dropped
        randomize_regs();
        run_round(20);
        repeat (ROUND_CYCLES + 3) @(negedge clk);

        // two-operator channels with cnt low then high
        for (int r = 0; r < 8; r++) begin
            if (r % 4 == 0)
                randomize_regs();
            for (int c = 0; c < NUM_CHANNELS; c++)
                cnt[c] = (r >= 4);
            run_round(0);
        end

        // four-operator chains over every cnt pair
        for (int k = 0; k < NUM_FOUR_OP_PAIRS; k++) begin
            randomize_regs();
            connection_sel = NUM_FOUR_OP_PAIRS'(1 << k);
            for (int combo = 0; combo < 4; combo++) begin
                cnt[k]     = combo[0];
                cnt[k + 3] = combo[1];
                run_round(0);
            end
        end

        // self feedback on modulators
        connection_sel = '0;
        randomize_regs();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            cnt[c] = 1'b0;
            fb[c]  = FB_WIDTH'(1 + ($random(seed) & 32'h7) % 7);
        end
        repeat (4) run_round(0);

        // key-off silences channels 0 and 4 until key-on restarts them
        kon[0] = 1'b0;
        kon[4] = 1'b0;
        run_round(0);
        foreach (operator_out[s]) begin
            if ((s == 0 || s == 3 || s == 7 || s == 10) && operator_out[s] !== '0) begin
                value_errors++;
                $display("Fail at %0t: operator_out[%0d] = %0d, expected 0",
                         $time, s, operator_out[s]);
            end
        end
        kon[0] = 1'b1;
        kon[4] = 1'b1;
        repeat (2) run_round(0);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/opl_operator_core.sv */
// ================================================
// Top of the FM operator core. One shared operator
// datapath is time-shared over 18 slots per sample
// strobe; sample_done marks the finished round.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module opl_operator_core
    import opl_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sample_clk_en,
    input  logic [FNUM_WIDTH-1:0]        fnum [NUM_CHANNELS],
    input  logic [BLOCK_WIDTH-1:0]       block [NUM_CHANNELS],
    input  logic                         kon [NUM_CHANNELS],
    input  logic [FB_WIDTH-1:0]          fb [NUM_CHANNELS],
    input  logic                         cnt [NUM_CHANNELS],
    input  logic [MULT_WIDTH-1:0]        mult [NUM_SLOTS],
    input  logic [TL_WIDTH-1:0]          tl [NUM_SLOTS],
    input  logic [NUM_FOUR_OP_PAIRS-1:0] connection_sel,
    output op_out_t                      operator_out [NUM_SLOTS],
    output logic                         sample_done
);

    logic [SLOT_WIDTH-1:0]  slot;
    logic                   busy;
    logic                   slot_start;
    logic                   slot_capture;
    logic [FNUM_WIDTH-1:0]  slot_fnum;
    logic [BLOCK_WIDTH-1:0] slot_block;
    logic                   slot_kon;
    logic [FB_WIDTH-1:0]    slot_fb;
    logic                   use_feedback;
    op_out_t                modulation;
    logic [MULT_WIDTH-1:0]  slot_mult;
    logic [TL_WIDTH-1:0]    slot_tl;
    logic [PHASE_WIDTH-1:0] phase;
    logic                   phase_valid;
    op_out_t                result;
    op_out_t                prev_out;

    // per-slot registers held at zero between rounds
    assign slot_mult = busy ? mult[slot] : '0;
    assign slot_tl   = busy ? tl[slot] : '0;

    op_slot_sequencer u_sequencer (
        .clk, .rst, .sample_clk_en,
        .slot, .busy, .slot_start, .slot_capture, .sample_done
    );

    op_connection_router u_router (
        .slot, .fnum, .block, .kon, .fb, .cnt, .connection_sel, .operator_out,
        .slot_fnum, .slot_block, .slot_kon, .slot_fb, .use_feedback, .modulation
    );

    op_phase_generator u_phase (
        .clk, .rst, .slot, .slot_start, .slot_fnum, .slot_block,
        .mult(slot_mult), .slot_kon, .phase, .phase_valid
    );

    op_waveform_unit u_waveform (
        .clk, .rst, .phase, .phase_valid, .modulation, .use_feedback, .slot_fb,
        .prev_out, .tl(slot_tl), .slot_kon, .result
    );

    op_output_bank u_outputs (
        .clk, .rst, .slot, .slot_capture, .result, .operator_out, .prev_out
    );

endmodule

`default_nettype wire

/* hw/op_output_bank.sv */
// ================================================
// Holds the last captured output of every slot.
// The current slot is written on slot_capture and
// its old value is offered back for self feedback.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module op_output_bank
    import opl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [SLOT_WIDTH-1:0] slot,
    input  logic                  slot_capture,
    input  op_out_t               result,
    output op_out_t               operator_out [NUM_SLOTS],
    output op_out_t               prev_out
);

    // value from the previous round until this slot's capture
    assign prev_out = operator_out[slot];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                operator_out[i] <= '0;
            end
        end else if (slot_capture) begin
            operator_out[slot] <= result;  // last cycle of the window
        end
    end

endmodule

`default_nettype wire

/* hw/op_waveform_unit.sv */
// ================================================
// Operator output stage. Adds modulation or self
// feedback to the phase, builds a triangle wave,
// attenuates by tl and registers on phase_valid.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module op_waveform_unit
    import opl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [PHASE_WIDTH-1:0] phase,
    input  logic                   phase_valid,
    input  op_out_t                modulation,
    input  logic                   use_feedback,
    input  logic [FB_WIDTH-1:0]    slot_fb,
    input  op_out_t                prev_out,
    input  logic [TL_WIDTH-1:0]    tl,
    input  logic                   slot_kon,
    output op_out_t                result
);

    logic [FB_WIDTH:0]             fb_shift;
    op_out_t                       fb_mod;
    op_out_t                       mod_sel;
    logic [WAVE_INDEX_WIDTH-1:0]   wave_index;
    logic [WAVE_INDEX_WIDTH-2:0]   half_index;  // index mod 512
    logic [WAVE_INDEX_WIDTH-3:0]   mag;
    logic [OP_OUT_WIDTH-2:0]       scaled;
    logic [OP_OUT_WIDTH-2:0]       atten;
    op_out_t                       signed_out;

    always_comb begin
        fb_shift = (FB_WIDTH + 1)'(FB_SHIFT_BASE - int'(slot_fb));
        fb_mod   = prev_out >>> fb_shift;  // last round's own output
        mod_sel  = (use_feedback && slot_fb != '0) ? fb_mod : modulation;

        // top phase bits plus low modulation bits wrap at 1024
        wave_index = phase[PHASE_WIDTH-1 -: WAVE_INDEX_WIDTH]
                   + mod_sel[WAVE_INDEX_WIDTH-1:0];
        half_index = wave_index[WAVE_INDEX_WIDTH-2:0];

        // rising below 256 and 511 - q above
        mag = half_index[WAVE_INDEX_WIDTH-2] ? ~half_index[WAVE_INDEX_WIDTH-3:0]
                                             : half_index[WAVE_INDEX_WIDTH-3:0];

        scaled = (OP_OUT_WIDTH - 1)'(mag) << MAG_SCALE_SHIFT;
        atten  = scaled >> tl[TL_WIDTH-1 -: TL_SHIFT_BITS];

        // second half of the cycle is negative
        if (wave_index[WAVE_INDEX_WIDTH-1]) begin
            signed_out = -$signed({1'b0, atten});
        end else begin
            signed_out = $signed({1'b0, atten});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (phase_valid) begin
            result <= slot_kon ? signed_out : '0;  // silent on key-off
        end
    end

endmodule

`default_nettype wire

/* hw/op_phase_generator.sv */
// ================================================
// Per-slot phase accumulators. On slot_start the
// current slot's phase advances by its increment,
// or clears on key-off, and is presented next cycle.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module op_phase_generator
    import opl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [SLOT_WIDTH-1:0]  slot,
    input  logic                   slot_start,
    input  logic [FNUM_WIDTH-1:0]  slot_fnum,
    input  logic [BLOCK_WIDTH-1:0] slot_block,
    input  logic [MULT_WIDTH-1:0]  mult,
    input  logic                   slot_kon,
    output logic [PHASE_WIDTH-1:0] phase,
    output logic                   phase_valid
);

    logic [PHASE_WIDTH-1:0] phase_mem [NUM_SLOTS];
    logic [PHASE_WIDTH-1:0] phase_inc;
    logic [PHASE_WIDTH-1:0] phase_next;

    always_comb begin
        // (fnum << block) * mult with low bits kept
        phase_inc  = (PHASE_WIDTH'(slot_fnum) << slot_block) * PHASE_WIDTH'(mult);
        phase_next = slot_kon ? phase_mem[slot] + phase_inc : '0;  // key-off restarts at 0
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                phase_mem[i] <= '0;
            end
            phase       <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= slot_start;
            if (slot_start) begin
                phase_mem[slot] <= phase_next;
                phase           <= phase_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/op_connection_router.sv */
// ================================================
// Maps channel registers onto the current slot and
// picks its modulation source. Handles 2-op pairs
// and the 4-op chains enabled by connection_sel.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module op_connection_router
    import opl_pkg::*;
(
    input  logic [SLOT_WIDTH-1:0]        slot,
    input  logic [FNUM_WIDTH-1:0]        fnum [NUM_CHANNELS],
    input  logic [BLOCK_WIDTH-1:0]       block [NUM_CHANNELS],
    input  logic                         kon [NUM_CHANNELS],
    input  logic [FB_WIDTH-1:0]          fb [NUM_CHANNELS],
    input  logic                         cnt [NUM_CHANNELS],
    input  logic [NUM_FOUR_OP_PAIRS-1:0] connection_sel,
    input  op_out_t                      operator_out [NUM_SLOTS],
    output logic [FNUM_WIDTH-1:0]        slot_fnum,
    output logic [BLOCK_WIDTH-1:0]       slot_block,
    output logic                         slot_kon,
    output logic [FB_WIDTH-1:0]          slot_fb,
    output logic                         use_feedback,
    output op_out_t                      modulation
);

    int unsigned grp;  // group of 6 slots serving 3 channels
    int unsigned pos;  // 0..2 modulators and 3..5 carriers
    int unsigned ch;
    int unsigned k;    // four-op pair index within the middle group

    always_comb begin
        grp = int'(slot) / SLOTS_PER_GROUP;
        pos = int'(slot) % SLOTS_PER_GROUP;
        k   = pos % CHANNELS_PER_GROUP;
        ch  = grp * CHANNELS_PER_GROUP + k;

        // two-operator mapping
        slot_fnum  = fnum[ch];
        slot_block = block[ch];
        slot_kon   = kon[ch];
        if (pos < CHANNELS_PER_GROUP) begin
            use_feedback = 1'b1;  // modulator
            slot_fb      = fb[ch];
            modulation   = '0;
        end else begin
            use_feedback = 1'b0;  // carrier fed by its modulator unless additive
            slot_fb      = '0;
            modulation   = cnt[ch] ? '0 : operator_out[int'(slot) - CHANNELS_PER_GROUP];
        end

        // slots k+6 and k+9 follow channel k when the pair is chained
        if (grp == FOUR_OP_GROUP && connection_sel[k]) begin
            slot_fnum    = fnum[k];
            slot_block   = block[k];
            slot_kon     = kon[k];
            use_feedback = 1'b0;
            slot_fb      = '0;
            if (pos < CHANNELS_PER_GROUP) begin  // third operator
                modulation = (!cnt[k] && cnt[k + CHANNELS_PER_GROUP]) ? '0
                           : operator_out[k + CHANNELS_PER_GROUP];
            end else begin  // last operator
                modulation = (cnt[k] && cnt[k + CHANNELS_PER_GROUP]) ? '0
                           : operator_out[k + SLOTS_PER_GROUP];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/op_slot_sequencer.sv */
// ================================================
// Walks the 18 operator slots after each sample
// strobe. Each slot gets a fixed window; start and
// capture strobes mark its first and last cycle.
// ================================================
`timescale 1ns/100ps
`default_nettype none

module op_slot_sequencer
    import opl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample_clk_en,
    output logic [SLOT_WIDTH-1:0] slot,
    output logic                  busy,
    output logic                  slot_start,
    output logic                  slot_capture,
    output logic                  sample_done
);

    logic [SLOT_DELAY_WIDTH-1:0] delay_cnt;  // cycle within the window
    logic                        window_end;
    logic                        last_slot;

    assign window_end = delay_cnt == SLOT_DELAY_WIDTH'(OP_SLOT_CYCLES - 1);
    assign last_slot  = slot == SLOT_WIDTH'(NUM_SLOTS - 1);

    assign slot_start   = busy && delay_cnt == '0;
    assign slot_capture = busy && window_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            slot        <= '0;
            delay_cnt   <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= 1'b0;
            if (!busy) begin
                if (sample_clk_en) begin  // strobes while busy are dropped
                    busy      <= 1'b1;
                    slot      <= '0;
                    delay_cnt <= '0;
                end
            end else if (window_end) begin
                delay_cnt <= '0;
                if (last_slot) begin
                    busy        <= 1'b0;  // back to idle
                    sample_done <= 1'b1;  // lands one cycle after last capture
                end else begin
                    slot <= slot + 1'b1;
                end
            end else begin
                delay_cnt <= delay_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/opl_pkg.sv */
// ================================================
// Shared sizes and slot timing for the FM operator
// core. Imported by every RTL module and by the
// testbench so both agree on widths and counts.
// ================================================
`default_nettype none

package opl_pkg;

    // register bank layout
    localparam int NUM_CHANNELS      = 9;
    localparam int NUM_SLOTS         = 18;
    localparam int NUM_FOUR_OP_PAIRS = 3;

    // slot map groups of 3 modulators then 3 carriers
    localparam int CHANNELS_PER_GROUP = 3;
    localparam int SLOTS_PER_GROUP    = 6;
    localparam int FOUR_OP_GROUP      = 1;  // slots 6..11 can join a chain

    // time sharing
    localparam int OP_SLOT_CYCLES   = 7;
    localparam int SLOT_DELAY_WIDTH = $clog2(OP_SLOT_CYCLES);

    // register field widths
    localparam int FNUM_WIDTH  = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int MULT_WIDTH  = 4;
    localparam int TL_WIDTH    = 6;
    localparam int FB_WIDTH    = 3;

    // operator datapath
    localparam int PHASE_WIDTH      = 20;
    localparam int WAVE_INDEX_WIDTH = 10;
    localparam int OP_OUT_WIDTH     = 13;
    localparam int SLOT_WIDTH       = 5;

    localparam int FB_SHIFT_BASE   = 8;  // feedback shift is 8 - fb
    localparam int MAG_SCALE_SHIFT = 4;  // triangle magnitude x16
    localparam int TL_SHIFT_BITS   = 3;  // top bits of tl used as shift

    typedef logic signed [OP_OUT_WIDTH-1:0] op_out_t;

endpackage

`default_nettype wire
